// File: hdl/recorder_lcd_pkg.sv
package recorder_lcd_pkg;

    typedef enum logic [3:0] {
        rec_none   = 4'd0,
        rec_play   = 4'd1,
        rec_pause  = 4'd2,
        rec_stop   = 4'd3,
        rec_record = 4'd4
    } rec_code_t;

    typedef logic [1:0] speed_mode_t;

    localparam speed_mode_t rec_slow = 2'd1; // everything else is fast

    typedef struct packed {
        rec_code_t   code;
        speed_mode_t mode;
        logic [3:0]  speed;
        logic        interpol;
        logic [4:0]  spare;
    } status_t;

    typedef struct packed {
        logic [3:0] minutes;
        logic [3:0] sec_tens;  // 0..5
        logic [3:0] sec_ones;  // 0..9
    } elapsed_t;

    typedef struct packed {
        logic       clear;
        logic [7:0] addr;
        logic [7:0] glyph;
    } lcd_cmd_t;

    localparam logic [7:0] addr_line1 = 8'h40;
    localparam logic [7:0] addr_time  = 8'h0c; // m:st in the last four slots

    localparam logic [7:0] glyph_zero   = 8'h30;
    localparam logic [7:0] glyph_colon  = 8'h3a;
    localparam logic [7:0] glyph_space  = 8'h20;
    localparam logic [7:0] glyph_slow   = 8'h2f; // '/'
    localparam logic [7:0] glyph_fast   = 8'h2a; // '*'
    localparam logic [7:0] glyph_interp = 8'h40; // '@'

    // labels padded to nine characters, first character in the top byte
    localparam logic [71:0] label_idle   = "Idle...  ";
    localparam logic [71:0] label_play   = "Play     ";
    localparam logic [71:0] label_pause  = "Pause    ";
    localparam logic [71:0] label_stop   = "Stop     ";
    localparam logic [71:0] label_record = "Recording";

    localparam int default_tick_cycles = 50_000_000;

endpackage

// File: hdl/status_capture.sv
module status_capture
    import recorder_lcd_pkg::*;
(
    input  logic    i_clk,
    input  logic    i_rst,
    input  status_t status,
    input  logic    resting,
    output status_t cur_status,
    output logic    status_new,
    output logic    code_new
);

    status_t sample;

    always_ff @(posedge i_clk or posedge i_rst) begin
        if (i_rst) begin
            sample     <= '0;
            cur_status <= '0;
            status_new <= 1'b1; // first draw comes straight out of reset
            code_new   <= 1'b1;
        end else begin
            status_new <= 1'b0;
            code_new   <= 1'b0;
            if (resting) begin
                sample <= status;
            end
            // one accept per rest period, the drawer leaves rest next cycle
            if (resting && !status_new && sample != cur_status) begin
                cur_status <= sample;
                status_new <= 1'b1;
                code_new   <= (sample.code != cur_status.code);
            end
        end
    end

    a_new_only_resting: assert property (
        @(posedge i_clk) disable iff (i_rst) status_new |-> resting
    ) else $error("status_new while drawer busy");

endmodule

// File: hdl/elapsed_timer.sv
module elapsed_timer
    import recorder_lcd_pkg::*;
#(
    parameter int tick_cycles = default_tick_cycles
) (
    input  logic     i_clk,
    input  logic     i_rst,
    input  logic     code_new,
    output elapsed_t elapsed
);

    localparam int div_w = $clog2(tick_cycles + 1);

    logic [div_w-1:0] div_cnt;
    logic             tick;

    assign tick = (div_cnt == div_w'(tick_cycles - 1)); // one second

    always_ff @(posedge i_clk or posedge i_rst) begin
        if (i_rst) begin
            div_cnt <= '0;
            elapsed <= '0;
        end else if (code_new) begin
            div_cnt <= '0; // new mode restarts the clock
            elapsed <= '0;
        end else begin
            div_cnt <= tick ? '0 : div_cnt + 1'b1;
            if (tick) begin
                if (elapsed.sec_ones == 4'd9) begin
                    elapsed.sec_ones <= 4'd0;
                    if (elapsed.sec_tens == 4'd5) begin
                        elapsed.sec_tens <= 4'd0;
                        elapsed.minutes  <= (elapsed.minutes == 4'd9) ? 4'd0
                                                                       : elapsed.minutes + 4'd1;
                    end else begin
                        elapsed.sec_tens <= elapsed.sec_tens + 4'd1;
                    end
                end else begin
                    elapsed.sec_ones <= elapsed.sec_ones + 4'd1;
                end
            end
        end
    end

    a_ones_bcd: assert property (
        @(posedge i_clk) disable iff (i_rst) elapsed.sec_ones <= 4'd9
    ) else $error("sec_ones out of range");

    a_tens_bcd: assert property (
        @(posedge i_clk) disable iff (i_rst) elapsed.sec_tens <= 4'd5
    ) else $error("sec_tens out of range");

endmodule

// File: hdl/screen_drawer.sv
module screen_drawer
    import recorder_lcd_pkg::*;
(
    input  logic     i_clk,
    input  logic     i_rst,
    input  status_t  cur_status,
    input  logic     status_new,
    input  elapsed_t elapsed,
    input  logic     port_ready,
    output lcd_cmd_t cmd,
    output logic     cmd_strobe,
    output logic     resting
);

    typedef enum logic [1:0] {
        st_rest,
        st_clear,
        st_write
    } state_t;

    state_t      state;
    logic [7:0]  addr;       // slot being written
    logic [7:0]  next_addr;
    logic        last_slot;
    logic [3:0]  lbl_len;
    logic [71:0] lbl_text;
    logic        has_time;
    logic [7:0]  glyph;

    always_comb begin
        case (cur_status.code)
            rec_none: begin
                lbl_len  = 4'd7;
                lbl_text = label_idle;
            end
            rec_play: begin
                lbl_len  = 4'd4;
                lbl_text = label_play;
            end
            rec_pause: begin
                lbl_len  = 4'd5;
                lbl_text = label_pause;
            end
            rec_stop: begin
                lbl_len  = 4'd4;
                lbl_text = label_stop;
            end
            rec_record: begin
                lbl_len  = 4'd9;
                lbl_text = label_record;
            end
            default: begin
                lbl_len  = 4'd0; // unknown code, line 1 only
                lbl_text = '0;
            end
        endcase
    end

    assign has_time = (cur_status.code == rec_play) || (cur_status.code == rec_record);

    // slot order: label, then time if any, then line 1
    always_comb begin
        next_addr = addr + 8'd1;
        last_slot = 1'b0;
        if (addr >= addr_line1) begin
            last_slot = (addr == addr_line1 + 8'd3);
        end else if (addr == addr_time + 8'd3) begin
            next_addr = addr_line1;
        end else if (addr < addr_time && addr[3:0] == lbl_len - 4'd1) begin
            next_addr = has_time ? addr_time : addr_line1;
        end
    end

    always_comb begin
        glyph = glyph_space;
        if (addr >= addr_line1) begin
            case (addr[1:0])
                2'd0: glyph = (cur_status.mode == rec_slow) ? glyph_slow : glyph_fast;
                2'd1: glyph = glyph_zero + {4'd0, cur_status.speed};
                2'd2: glyph = glyph_space;
                default: glyph = cur_status.interpol ? glyph_interp : glyph_zero;
            endcase
        end else if (addr >= addr_time) begin
            case (addr[1:0]) // digits sampled as the slot goes out
                2'd0: glyph = glyph_zero + {4'd0, elapsed.minutes};
                2'd1: glyph = glyph_colon;
                2'd2: glyph = glyph_zero + {4'd0, elapsed.sec_tens};
                default: glyph = glyph_zero + {4'd0, elapsed.sec_ones};
            endcase
        end else begin
            glyph = lbl_text[8'd71 - {addr[3:0], 3'b000} -: 8];
        end
    end

    assign cmd.clear  = (state == st_clear);
    assign cmd.addr   = (state == st_clear) ? 8'h00 : addr;
    assign cmd.glyph  = (state == st_clear) ? 8'h00 : glyph;
    assign cmd_strobe = (state != st_rest) && port_ready;
    assign resting    = (state == st_rest);

    always_ff @(posedge i_clk or posedge i_rst) begin
        if (i_rst) begin
            state <= st_rest;
            addr  <= 8'h00;
        end else begin
            case (state)
                st_rest: begin
                    if (status_new) begin
                        state <= st_clear;
                    end
                end
                st_clear: begin
                    if (port_ready) begin
                        state <= st_write;
                        addr  <= (lbl_len != 4'd0) ? 8'h00 : addr_line1;
                    end
                end
                default: begin
                    if (port_ready) begin
                        addr <= next_addr;
                        if (last_slot) begin
                            state <= st_rest;
                        end
                    end
                end
            endcase
        end
    end

endmodule

// File: hdl/lcd_command_port.sv
module lcd_command_port
    import recorder_lcd_pkg::*;
(
    input  logic       i_clk,
    input  logic       i_rst,
    input  lcd_cmd_t   cmd,
    input  logic       cmd_strobe,
    input  logic       lcd_busy,
    output logic       port_ready,
    output logic [7:0] lcd_char,
    output logic [7:0] lcd_addr,
    output logic       lcd_start,
    output logic       lcd_clear
);

    // busy only rises on the edge after a pulse, so block that cycle too
    assign port_ready = !lcd_busy && !lcd_start && !lcd_clear;

    always_ff @(posedge i_clk or posedge i_rst) begin
        if (i_rst) begin
            lcd_start <= 1'b0;
            lcd_clear <= 1'b0;
        end else begin
            lcd_start <= cmd_strobe && !cmd.clear; // single cycle pulses
            lcd_clear <= cmd_strobe && cmd.clear;
        end
    end

    always_ff @(posedge i_clk) begin
        if (cmd_strobe) begin
            lcd_addr <= cmd.addr; // held until next command
            lcd_char <= cmd.glyph;
        end
    end

    a_no_pulse_busy: assert property (
        @(posedge i_clk) disable iff (i_rst) (lcd_start || lcd_clear) |-> !lcd_busy
    ) else $error("pulse while display busy");

    a_start_clear_excl: assert property (
        @(posedge i_clk) disable iff (i_rst) !(lcd_start && lcd_clear)
    ) else $error("start and clear together");

endmodule

// File: hdl/recorder_lcd_top.sv
module recorder_lcd_top
    import recorder_lcd_pkg::*;
#(
    parameter int tick_cycles = default_tick_cycles
) (
    input  logic       i_clk,
    input  logic       i_rst,
    input  status_t    status,
    input  logic       lcd_busy,
    output logic [7:0] lcd_char,
    output logic [7:0] lcd_addr,
    output logic       lcd_start,
    output logic       lcd_clear
);

    status_t  cur_status;
    logic     status_new;
    logic     code_new;
    logic     resting;
    elapsed_t elapsed;
    lcd_cmd_t cmd;
    logic     cmd_strobe;
    logic     port_ready;

    status_capture u_capture (
        .i_clk      (i_clk),
        .i_rst      (i_rst),
        .status     (status),
        .resting    (resting),
        .cur_status (cur_status),
        .status_new (status_new),
        .code_new   (code_new)
    );

    elapsed_timer #(
        .tick_cycles (tick_cycles)
    ) u_timer (
        .i_clk    (i_clk),
        .i_rst    (i_rst),
        .code_new (code_new),
        .elapsed  (elapsed)
    );

    screen_drawer u_drawer (
        .i_clk      (i_clk),
        .i_rst      (i_rst),
        .cur_status (cur_status),
        .status_new (status_new),
        .elapsed    (elapsed),
        .port_ready (port_ready),
        .cmd        (cmd),
        .cmd_strobe (cmd_strobe),
        .resting    (resting)
    );

    lcd_command_port u_port (
        .i_clk      (i_clk),
        .i_rst      (i_rst),
        .cmd        (cmd),
        .cmd_strobe (cmd_strobe),
        .lcd_busy   (lcd_busy),
        .port_ready (port_ready),
        .lcd_char   (lcd_char),
        .lcd_addr   (lcd_addr),
        .lcd_start  (lcd_start),
        .lcd_clear  (lcd_clear)
    );

endmodule

// File: tests/lcd_checker.sv
module lcd_checker
    import recorder_lcd_pkg::*;
(
    input  logic       i_clk,
    input  logic       i_rst,
    input  status_t    status,
    input  int         test_id,
    input  int         exp_count,
    input  logic       lcd_busy,
    input  logic [7:0] lcd_char,
    input  logic [7:0] lcd_addr,
    input  logic       lcd_start,
    input  logic       lcd_clear,
    output int         screens_done,
    output int         tests_bad,
    output int         errors
);

    timeunit 1ns;
    timeprecision 1ps;

    status_t    pend_status[$]; // one entry per status change
    int         pend_cycle[$];
    int         pend_test[$];
    int         pend_count[$];
    logic [7:0] exp_addr[$];
    logic [7:0] exp_glyph[$];
    int         exp_kind[$];    // 0 fixed, 1 minute, 2 tens, 3 ones
    status_t    last_status;
    status_t    scr_status;
    rec_code_t  prev_code;
    logic       scr_open;
    logic       first;
    int         cyc = 0;
    int         idx;
    int         scr_test;
    int         scr_count;
    int         scr_errs;
    int         clk_clear;      // clock restart window of the last code change
    int         clk_change;
    int         shown_min;
    int         shown_tens;
    int         last_shown;     // seconds shown on the last time screen
    logic       have_last;

    function automatic logic digit_fits(input int kind, input int d, input int lo, input int hi);
        int t;
        digit_fits = 1'b0;
        for (t = lo; t <= hi; t++) begin
            if ((kind == 1 && (t / 60) % 10 == d) || (kind == 2 && (t % 60) / 10 == d) ||
                (kind == 3 && t % 10 == d)) begin
                digit_fits = 1'b1;
            end
        end
    endfunction

    task automatic add_slot(input logic [7:0] a, input logic [7:0] g, input int k);
        exp_addr.push_back(a);
        exp_glyph.push_back(g);
        exp_kind.push_back(k);
    endtask

    task automatic build_screen(input status_t st);
        string lbl;
        int    i;
        exp_addr.delete();
        exp_glyph.delete();
        exp_kind.delete();
        case (st.code)
            rec_none:   lbl = "Idle...";
            rec_play:   lbl = "Play";
            rec_pause:  lbl = "Pause";
            rec_stop:   lbl = "Stop";
            rec_record: lbl = "Recording";
            default:    lbl = "";
        endcase
        for (i = 0; i < lbl.len(); i++) begin
            add_slot(8'(i), lbl[i], 0);
        end
        if (st.code == rec_play || st.code == rec_record) begin
            for (i = 1; i <= 4; i++) begin // m:st at 0c
                add_slot(8'h0b + 8'(i), (i == 2) ? 8'h3a : 8'h00,
                         (i == 2) ? 0 : (i == 1) ? 1 : i - 1);
            end
        end
        add_slot(8'h40, (st.mode == 2'd1) ? 8'h2f : 8'h2a, 0);
        add_slot(8'h41, 8'h30 + {4'd0, st.speed}, 0);
        add_slot(8'h42, 8'h20, 0);
        add_slot(8'h43, st.interpol ? 8'h40 : 8'h30, 0);
    endtask

    task automatic value_error(input string name, input logic [7:0] expv, input logic [7:0] got);
        scr_errs++;
        errors++;
        $display("Fail test %0d %s at slot %0d: expected %h, got %h",
                 scr_test, name, idx, expv, got);
    endtask

    task automatic finish_screen();
        if (idx != scr_count) begin
            scr_errs++;
            errors++;
            $display("Fail test %0d write_count: expected %h, got %h", scr_test, scr_count, idx);
        end
        if (scr_errs != 0) begin
            tests_bad++;
        end
        $display("test %0d status %h: %0d writes, %0d errors", scr_test, scr_status, idx, scr_errs);
        screens_done++;
        scr_open = 1'b0;
    endtask

    task automatic open_screen();
        int change;
        scr_status = pend_status.pop_front();
        change     = pend_cycle.pop_front();
        scr_test   = pend_test.pop_front();
        scr_count  = pend_count.pop_front();
        build_screen(scr_status);
        if (first || scr_status.code != prev_code) begin
            clk_clear  = cyc;
            clk_change = change;
            have_last  = 1'b0; // clock restarted
        end
        first     = 1'b0;
        prev_code = scr_status.code;
        idx       = 0;
        scr_errs  = 0;
        scr_open  = 1'b1;
    endtask

    task automatic check_time(input int kind, input int d);
        int shown;
        if (kind == 1) begin
            shown_min = d;
        end else if (kind == 2) begin
            shown_tens = d;
        end else begin
            shown = shown_min * 60 + shown_tens * 10 + d;
            if (have_last && shown < last_shown) begin
                scr_errs++;
                errors++;
                $display("Fail test %0d elapsed: expected at least %h, got %h",
                         scr_test, last_shown, shown);
            end
            last_shown = shown;
            have_last  = 1'b1;
        end
    endtask

    task automatic check_write();
        int lo;
        int hi;
        int d;
        if (!scr_open) begin
            errors++;
            $display("write to address %h arrived with no screen open", lcd_addr);
        end else begin
            lo = (cyc - clk_clear) / 16; // seconds since the clock restarted
            hi = (cyc - clk_change) / 16;
            d  = int'(lcd_char) - 48;
            if (lcd_addr != exp_addr[idx]) begin
                value_error("lcd_addr", exp_addr[idx], lcd_addr);
            end else if (exp_kind[idx] == 0) begin
                if (lcd_char != exp_glyph[idx]) begin
                    value_error("lcd_char", exp_glyph[idx], lcd_char);
                end
            end else if (d < 0 || d > 9 || !digit_fits(exp_kind[idx], d, lo, hi)) begin
                scr_errs++;
                errors++;
                $display("Fail test %0d lcd_char at addr %h: expected digit of %h to %h ticks, got %h",
                         scr_test, lcd_addr, lo, hi, lcd_char);
            end else begin
                check_time(exp_kind[idx], d);
            end
            idx++;
            if (idx == exp_addr.size()) begin
                finish_screen();
            end
        end
    endtask

    always @(posedge i_clk) begin
        cyc = cyc + 1;
        if (i_rst) begin
            pend_status.delete();
            pend_cycle.delete();
            pend_test.delete();
            pend_count.delete();
            pend_status.push_back('0); // reset forces a draw of status zero
            pend_cycle.push_back(cyc);
            pend_test.push_back(test_id);
            pend_count.push_back(exp_count);
            last_status  = '0;
            scr_open     = 1'b0;
            first        = 1'b1;
            have_last    = 1'b0;
            shown_min    = 0;
            shown_tens   = 0;
            last_shown   = 0;
            screens_done = 0;
            tests_bad    = 0;
            errors       = 0;
        end else begin
            if (status != last_status) begin
                pend_status.push_back(status);
                pend_cycle.push_back(cyc);
                pend_test.push_back(test_id);
                pend_count.push_back(exp_count);
            end
            last_status = status;
            if ((lcd_start || lcd_clear) && lcd_busy) begin
                errors++;
                $display("pulse on the display pins while lcd_busy is high, cycle %0d", cyc);
            end
            if (lcd_clear) begin
                if (scr_open) begin
                    finish_screen(); // cut short by a new clear
                end
                if (pend_status.size() == 0) begin
                    errors++;
                    $display("clear at cycle %0d with no status change waiting", cyc);
                end else begin
                    open_screen();
                end
            end
            if (lcd_start) begin
                check_write();
            end
        end
    end

endmodule

// File: tests/tb_recorder_lcd.sv
module tb_recorder_lcd
    import recorder_lcd_pkg::*;
();

    timeunit 1ns;
    timeprecision 1ps;

    localparam int max_tests = 32;

    logic       i_clk;
    logic       i_rst;
    status_t    status;
    logic       lcd_busy = 1'b0;
    logic [7:0] lcd_char;
    logic [7:0] lcd_addr;
    logic       lcd_start;
    logic       lcd_clear;

    int          test_id;
    int          exp_count;
    int          busy_len;
    int          busy_left = 0;
    int          cycles = 0;
    int          limit = 0;
    int          n_tests;
    int          screens_done;
    int          tests_bad;
    int          errors;
    logic [7:0]  lfsr = 8'd85;
    int          v_id[max_tests];
    logic [15:0] v_status[max_tests];
    int          v_hold[max_tests];
    int          v_busy[max_tests];
    int          v_count[max_tests];

    recorder_lcd_top #(
        .tick_cycles (16)
    ) dut0 (
        .i_clk     (i_clk),
        .i_rst     (i_rst),
        .status    (status),
        .lcd_busy  (lcd_busy),
        .lcd_char  (lcd_char),
        .lcd_addr  (lcd_addr),
        .lcd_start (lcd_start),
        .lcd_clear (lcd_clear)
    );

    lcd_checker mon0 (
        .i_clk        (i_clk),
        .i_rst        (i_rst),
        .status       (status),
        .test_id      (test_id),
        .exp_count    (exp_count),
        .lcd_busy     (lcd_busy),
        .lcd_char     (lcd_char),
        .lcd_addr     (lcd_addr),
        .lcd_start    (lcd_start),
        .lcd_clear    (lcd_clear),
        .screens_done (screens_done),
        .tests_bad    (tests_bad),
        .errors       (errors)
    );

    initial begin
        i_clk = 1'b0;
        forever #20 i_clk = ~i_clk;
    end

    function automatic logic [7:0] lfsr_next(input logic [7:0] s);
        lfsr_next = s[0] ? ((s >> 1) ^ 8'hb8) : (s >> 1);
    endfunction

    task automatic random_busy(output int len);
        int i;
        len = 1;
        for (i = 0; i < 4; i++) begin
            len = len + (int'(lfsr[0]) << i); // one step per bit
            lfsr = lfsr_next(lfsr);
        end
    endtask

    // display model, busy from the edge after each pulse
    always @(posedge i_clk) begin
        if (lcd_start || lcd_clear) begin
            if (busy_len == 0) begin
                random_busy(busy_left);
            end else begin
                busy_left = busy_len;
            end
            lcd_busy <= 1'b1;
        end else if (busy_left > 1) begin
            busy_left = busy_left - 1;
        end else begin
            busy_left = 0;
            lcd_busy <= 1'b0;
        end
    end

    always @(posedge i_clk) begin
        cycles <= cycles + 1;
        if (limit > 0 && cycles > limit) begin
            $display("timeout after %0d cycles, the DUT stopped drawing", cycles);
            $display("tests failed");
            $finish;
        end
    end

    task automatic read_vectors();
        int          fd;
        int          got;
        int          id;
        int          hold;
        int          busy;
        int          cnt;
        logic [15:0] sw;
        string       line;
        n_tests = 0;
        fd = $fopen("tests/lcd_vectors.txt", "r");
        if (fd != 0) begin
            while (!$feof(fd) && n_tests < max_tests) begin
                line = "";
                got = $fgets(line, fd);
                if (got > 0 && line.len() > 0 && line[0] != "#") begin
                    if ($sscanf(line, "%d %h %d %d %d", id, sw, hold, busy, cnt) == 5) begin
                        v_id[n_tests]     = id;
                        v_status[n_tests] = sw;
                        v_hold[n_tests]   = hold;
                        v_busy[n_tests]   = busy;
                        v_count[n_tests]  = cnt;
                        n_tests++;
                    end
                end
            end
            $fclose(fd);
        end
    endtask

    task automatic wait_clear();
        do begin
            @(posedge i_clk);
        end while (!lcd_clear);
    endtask

    task automatic run_all();
        int k;
        int hold_sum;
        hold_sum = 0;
        for (k = 0; k < n_tests; k++) begin
            hold_sum += v_hold[k];
        end
        limit = hold_sum + 400 * (n_tests + 1); // reset screen counts as one
        repeat (8) @(posedge i_clk);
        i_rst <= 1'b0;
        wait_clear();
        for (k = 0; k < n_tests; k++) begin
            @(posedge i_clk);
            status    <= v_status[k];
            test_id   <= v_id[k];
            exp_count <= v_count[k];
            busy_len  <= v_busy[k];
            wait_clear();
            repeat (v_hold[k]) @(posedge i_clk); // short hold lands in the draw
        end
        while (screens_done < n_tests + 1) begin
            @(posedge i_clk);
        end
        repeat (50) @(posedge i_clk); // stray screens show up here
    endtask

    initial begin
        i_rst     = 1'b1;
        status    = '0;
        test_id   = 0;
        exp_count = 11;
        busy_len  = 2;
        read_vectors();
        if (n_tests == 0) begin
            $display("no vectors could be read from tests/lcd_vectors.txt");
            $display("tests failed");
            $finish;
        end else begin
            run_all();
            $display("%0d screens checked, %0d with errors, %0d errors in all",
                     screens_done, tests_bad, errors);
            if (errors == 0 && tests_bad == 0) begin
                $display("all tests passed");
            end else begin
                $display("tests failed");
            end
            $finish;
        end
    end

endmodule

// File: tests/lcd_vectors.txt
# test id, status word (hex), hold cycles after the clear, busy length (0 = random),
# expected write count
1 10c0 40 2 12
2 1560 60 3 12
3 2080 2 4 9
4 4a60 30 0 17
5 3400 1 5 8
6 01e0 20 0 11
7 7c40 10 1 4
8 43c5 3 12 17
9 43c6 50 0 17
10 1000 20 6 12

// File: verilog.f
hdl/recorder_lcd_pkg.sv
hdl/status_capture.sv
hdl/elapsed_timer.sv
hdl/screen_drawer.sv
hdl/lcd_command_port.sv
hdl/recorder_lcd_top.sv
tests/lcd_checker.sv
tests/tb_recorder_lcd.sv

// File: run_sim.sh
#!/bin/sh
cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert --timescale 1ns/1ps -f verilog.f \
    --top-module tb_recorder_lcd -Mdir obj_dir -o sim_recorder_lcd
if [ $? -ne 0 ]; then
    echo "verilator build failed"
    exit 1
fi

./obj_dir/sim_recorder_lcd > sim.log 2>&1
sim_status=$?
cat sim.log
if [ $sim_status -ne 0 ]; then
    echo "simulation exited with status $sim_status"
    exit 1
fi

if grep -q "^all tests passed$" sim.log; then
    exit 0
fi
exit 1
